/* Makefile */
VERILATOR  = verilator
FLAGS      = --binary --timing --assert --timescale 1ns/1ps -j 0
LINT_FLAGS = --lint-only --timing --assert --timescale 1ns/1ps
TOP        = tb_mk_loader
FILELIST   = compile.f
OBJ_DIR    = obj_dir
PASS_MSG   = SIMULATION PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# grep decides the exit status of the pipeline
run: build
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* bench/tb_mk_loader.sv */
`timescale 1ns/1ps
`default_nettype none

`include "loader_cfg.svh"

module tb_mk_loader;

    localparam int N  = `LD_NUM_PES;
    localparam int DW = `LD_DATA_W;
    localparam int PW = `LD_LOG2_PES;
    localparam int VW = `LD_LOG2_PEGS;

    // cycle budget of each test, reset counted with the first
    localparam int CYC_RESET    = 10;
    localparam int CYC_PACK     = 45;
    localparam int CYC_PAD      = 40;
    localparam int CYC_CROSS    = 40;
    localparam int CYC_BOUNDARY = 35;
    localparam int CYC_LAST_BLK = 30;
    localparam int CYC_DRAIN    = 10;
    localparam int WATCHDOG_CYCLES = 2 * (CYC_RESET + CYC_PACK + CYC_PAD + CYC_CROSS +
                                          CYC_BOUNDARY + CYC_LAST_BLK + CYC_DRAIN) + 100;

    typedef struct packed {
        mk_loader_pkg::fifo_word_t word;
        int                        due;
    } exp_word_t;

    logic                      clk;
    logic                      rst;
    logic                      group_valid;
    mk_loader_pkg::group_t     group;
    mk_loader_pkg::fifo_word_t word;
    logic                      wr_en;
    logic                      busy;

    integer seed;
    int     cyc = 0;
    int     busy_at = -1;
    int     err_value = 0;
    int     err_other = 0;
    int     row_cnt = 0;
    string  test_name = "reset";

    // reference ring model
    // slot s sits in lane s % N of half s / N
    mk_loader_pkg::lane_t m_ring [2*N];
    int                   m_ptr = 0;
    exp_word_t            exp_q [$];
    exp_word_t            head;
    logic                 head_valid = 1'b0;

    mk_loader_top mk_loader_top_inst (
        .clk         (clk),
        .rst         (rst),
        .group_valid (group_valid),
        .group       (group),
        .word        (word),
        .wr_en       (wr_en),
        .busy        (busy)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // drop words whose due cycle has passed
    always @(negedge clk) begin
        while (exp_q.size() > 0 && exp_q[0].due < cyc) begin
            void'(exp_q.pop_front());
        end
        head_valid = exp_q.size() > 0;
        if (head_valid) begin
            head = exp_q[0];
        end
    end

    word_expected: assert property (@(posedge clk) disable iff (rst)
        wr_en |-> head_valid && head.due == cyc)
        else begin
            $display("unexpected write pulse at cycle %0d in %s", $sampled(cyc), test_name);
            err_other++;
        end

    word_written: assert property (@(posedge clk) disable iff (rst)
        (head_valid && head.due == cyc) |-> wr_en)
        else begin
            $display("expected word missing at cycle %0d in %s", $sampled(cyc), test_name);
            err_other++;
        end

    lanes_match: assert property (@(posedge clk) disable iff (rst)
        (wr_en && head_valid && head.due == cyc) |-> word.lanes == head.word.lanes)
        else begin
            $display("ERR %s lanes expected %h actual %h", test_name, head.word.lanes,
                     $sampled(word.lanes));
            err_value++;
        end

    flags_match: assert property (@(posedge clk) disable iff (rst)
        (wr_en && head_valid && head.due == cyc) |->
            {word.block_end, word.last_block} == {head.word.block_end, head.word.last_block})
        else begin
            $display("ERR %s flags expected %b%b actual %b%b", test_name,
                     head.word.block_end, head.word.last_block, $sampled(word.block_end),
                     $sampled(word.last_block));
            err_value++;
        end

    busy_match: assert property (@(posedge clk) disable iff (rst) busy == (cyc == busy_at))
        else begin
            $display("ERR %s busy expected %0b actual %0b", test_name,
                     $sampled(cyc) == busy_at, $sampled(busy));
            err_value++;
        end

    function automatic int rand_below(input int n);
        int r;
        r = $random(seed);
        return (r & 32'h7fff_ffff) % n;
    endfunction

    task automatic push_word(input int half, input logic block_end, input logic last_block,
                             input int due);
        exp_word_t e;
        int        i;
        for (i = 0; i < N; i++) begin
            e.word.lanes[i] = m_ring[half * N + i];
        end
        e.word.block_end  = block_end;
        e.word.last_block = last_block;
        e.due             = due;
        exp_q.push_back(e);
    endtask

    task automatic model_group(input mk_loader_pkg::group_t g);
        int cur_half;
        int last_half;
        int due;
        int i;
        int s;
        due      = cyc + 2;
        cur_half = m_ptr / N;
        for (i = 0; i < int'(g.len); i++) begin
            s = (m_ptr + i) % (2 * N);
            m_ring[s].data = g.data[i];
            m_ring[s].dest = g.dest[i];
            m_ring[s].vn   = g.vn;
        end
        if (!g.last_row) begin
            if (m_ptr % N + int'(g.len) >= N) begin
                push_word(cur_half, 1'b0, 1'b0, due);
            end
            m_ptr = (m_ptr + int'(g.len)) % (2 * N);
        end else begin
            // half holding the last element or the current half when empty
            if (g.len == 0) begin
                last_half = cur_half;
            end else begin
                last_half = ((m_ptr + int'(g.len) - 1) % (2 * N)) / N;
            end
            s = (m_ptr + int'(g.len)) % (2 * N);
            while (s / N == last_half) begin
                m_ring[s].data = '0;
                m_ring[s].dest = '1;
                m_ring[s].vn   = g.vn;
                s = (s + 1) % (2 * N);
            end
            if (last_half != cur_half) begin
                push_word(cur_half, 1'b0, 1'b0, due);
                push_word(last_half, 1'b1, g.last_block, due + 1);
                busy_at = due;
            end else begin
                push_word(cur_half, 1'b1, g.last_block, due);
            end
            m_ptr = (1 - last_half) * N;
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge clk);
            group_valid = 1'b0;
        end
    endtask

    task automatic drive_group(input int len, input logic last_row, input logic last_block);
        mk_loader_pkg::group_t g;
        int                    i;
        g = '0;
        for (i = 0; i < N; i++) begin
            g.data[i] = DW'(rand_below(1 << DW));
            g.dest[i] = PW'(rand_below(N));
        end
        g.len        = (PW + 1)'(len);
        g.vn         = VW'(row_cnt % `LD_NUM_PEGS);
        g.last_row   = last_row;
        g.last_block = last_block;
        row_cnt++;
        @(negedge clk);
        group       = g;
        group_valid = 1'b1;
        model_group(g);
        if (last_row) begin
            // emitter may still flush a second word
            idle_cycles(2);
        end
    endtask

    task automatic send_random(input int n);
        repeat (n) begin
            drive_group(rand_below(N + 1), 1'b0, 1'b0);
        end
    endtask

    task automatic drive_pad_inside(input logic last_block);
        int pos;
        pos = m_ptr % N;
        if (pos == 0) begin
            drive_group(1 + rand_below(N - 1), 1'b1, last_block);
        end else begin
            drive_group(rand_below(N - pos), 1'b1, last_block);
        end
    endtask

    task automatic drive_crossing(input logic last_block);
        int pos;
        if (m_ptr % N == 0) begin
            drive_group(1 + rand_below(N - 1), 1'b0, 1'b0);
        end
        pos = m_ptr % N;
        drive_group(N - pos + 1 + rand_below(pos), 1'b1, last_block);
    endtask

    initial begin
        int i;
        seed        = 28348;
        clk         = 1'b0;
        rst         = 1'b1;
        group_valid = 1'b0;
        group       = '0;
        for (i = 0; i < 2 * N; i++) begin
            m_ring[i] = '0;
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        test_name = "reset_idle";
        idle_cycles(5);

        test_name = "pack_order";
        send_random(40);

        test_name = "pad_in_half";
        repeat (6) begin
            send_random(3);
            drive_pad_inside(1'b0);
        end

        test_name = "cross_flush";
        repeat (6) begin
            send_random(2);
            drive_crossing(1'b0);
        end

        test_name = "half_boundary";
        repeat (4) begin
            send_random(2);
            drive_group(N - m_ptr % N, 1'b1, 1'b0);
            drive_group(0, 1'b1, 1'b0);
        end

        test_name = "last_block";
        send_random(3);
        drive_crossing(1'b1);
        send_random(2);
        drive_group(N - m_ptr % N, 1'b1, 1'b1);
        drive_group(0, 1'b1, 1'b1);
        drive_pad_inside(1'b1);
        send_random(4);

        test_name = "drain";
        idle_cycles(6);

        $display("errors: %0d wrong values, %0d other failures", err_value, err_other);
        if (err_value + err_other == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, stimulus never finished",
                 WATCHDOG_CYCLES);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
+incdir+design
design/mk_loader_pkg.sv
design/ring_pointer.sv
design/lane_router.sv
design/half_buffer.sv
design/word_emitter.sv
design/mk_loader_top.sv
bench/tb_mk_loader.sv

/* design/half_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "loader_cfg.svh"

module half_buffer (
    input  logic                   clk,
    input  logic                   rst,
    input  mk_loader_pkg::half_t   lanes_in,
    input  logic [`LD_NUM_PES-1:0] write,
    input  logic [`LD_NUM_PES-1:0] fill,
    output mk_loader_pkg::half_t   lanes
);

    localparam int N = `LD_NUM_PES;

    logic [N-1:0] load;

    // element or fill, both come in through lanes_in
    assign load = write | fill;

    always_ff @(posedge clk) begin
        if (rst) begin
            lanes <= '0;
        end else begin
            for (int i = 0; i < N; i++) begin
                if (load[i]) begin
                    lanes[i] <= lanes_in[i];
                end
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst) (write & fill) == '0)
        else $error("lane both written and filled: write=%b fill=%b", write, fill);

endmodule

`default_nettype wire

/* design/lane_router.sv */
`timescale 1ns/1ps
`default_nettype none

`include "loader_cfg.svh"

module lane_router (
    input  mk_loader_pkg::group_t    group,
    input  mk_loader_pkg::slot_ctl_t slot_ctl,
    output mk_loader_pkg::half_t     lanes_lo,
    output mk_loader_pkg::half_t     lanes_hi,
    output logic [`LD_NUM_PES-1:0]   write_lo,
    output logic [`LD_NUM_PES-1:0]   write_hi,
    output logic [`LD_NUM_PES-1:0]   fill_lo,
    output logic [`LD_NUM_PES-1:0]   fill_hi
);

    localparam int N = `LD_NUM_PES;

    mk_loader_pkg::lane_t [2*N-1:0] ring;
    logic [2*N-1:0]                 ring_write;
    logic [2*N-1:0]                 ring_fill;

    always_comb begin
        for (int s = 0; s < 2 * N; s++) begin
            if (slot_ctl[s].fill) begin
                // fill lane, dest all ones marks it empty downstream
                ring[s].data = '0;
                ring[s].dest = '1;
            end else begin
                ring[s].data = group.data[slot_ctl[s].src];
                ring[s].dest = group.dest[slot_ctl[s].src];
            end
            ring[s].vn    = group.vn;
            ring_write[s] = slot_ctl[s].write;
            ring_fill[s]  = slot_ctl[s].fill;
        end
    end

    // lower slots form half 0
    assign lanes_lo = ring[N-1:0];
    assign lanes_hi = ring[2*N-1:N];
    assign write_lo = ring_write[N-1:0];
    assign write_hi = ring_write[2*N-1:N];
    assign fill_lo  = ring_fill[N-1:0];
    assign fill_hi  = ring_fill[2*N-1:N];

endmodule

`default_nettype wire

/* design/loader_cfg.svh */
`ifndef LOADER_CFG_SVH
`define LOADER_CFG_SVH

// lanes per staging half, one FIFO word
`define LD_NUM_PES 8

// destination and lane index width
`define LD_LOG2_PES 3

// row groups per block
`define LD_NUM_PEGS 8

// row tag width
`define LD_LOG2_PEGS 3

// element width
`define LD_DATA_W 8

`endif

/* design/mk_loader_pkg.sv */
`default_nettype none

`include "loader_cfg.svh"

package mk_loader_pkg;

    // one lane of a staging half
    typedef struct packed {
        logic [`LD_DATA_W-1:0]    data;
        logic [`LD_LOG2_PES-1:0]  dest;
        logic [`LD_LOG2_PEGS-1:0] vn;
    } lane_t;

    typedef lane_t [`LD_NUM_PES-1:0] half_t;

    // one compressed row group, len counts valid elements from index 0
    typedef struct packed {
        logic [`LD_NUM_PES-1:0][`LD_DATA_W-1:0]   data;
        logic [`LD_NUM_PES-1:0][`LD_LOG2_PES-1:0] dest;
        logic [`LD_LOG2_PES:0]                    len;
        logic [`LD_LOG2_PEGS-1:0]                 vn;
        logic                                     last_row;
        logic                                     last_block;
    } group_t;

    typedef struct packed {
        logic                    write;
        logic                    fill;
        logic [`LD_LOG2_PES-1:0] src;
    } slot_t;

    typedef slot_t [2*`LD_NUM_PES-1:0] slot_ctl_t;

    typedef struct packed {
        logic first_valid;
        logic first_half;
        logic second_valid;
        logic block_end;
        logic last_block;
    } emit_req_t;

    typedef struct packed {
        half_t lanes;
        logic  block_end;
        logic  last_block;
    } fifo_word_t;

endpackage

`default_nettype wire

/* design/mk_loader_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "loader_cfg.svh"

module mk_loader_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      group_valid,
    input  mk_loader_pkg::group_t     group,
    output mk_loader_pkg::fifo_word_t word,
    output logic                      wr_en,
    output logic                      busy
);

    mk_loader_pkg::slot_ctl_t slot_ctl;
    mk_loader_pkg::emit_req_t emit_req;
    mk_loader_pkg::half_t     lanes_lo;
    mk_loader_pkg::half_t     lanes_hi;
    mk_loader_pkg::half_t     half_lo;
    mk_loader_pkg::half_t     half_hi;
    logic [`LD_NUM_PES-1:0]   write_lo;
    logic [`LD_NUM_PES-1:0]   write_hi;
    logic [`LD_NUM_PES-1:0]   fill_lo;
    logic [`LD_NUM_PES-1:0]   fill_hi;

    ring_pointer ring_pointer_inst (
        .clk         (clk),
        .rst         (rst),
        .group_valid (group_valid),
        .group       (group),
        .slot_ctl    (slot_ctl),
        .emit_req    (emit_req),
        .busy        (busy)
    );

    lane_router lane_router_inst (
        .group    (group),
        .slot_ctl (slot_ctl),
        .lanes_lo (lanes_lo),
        .lanes_hi (lanes_hi),
        .write_lo (write_lo),
        .write_hi (write_hi),
        .fill_lo  (fill_lo),
        .fill_hi  (fill_hi)
    );

    // ring slots 0 .. NUM_PES-1
    half_buffer half_lo_inst (
        .clk      (clk),
        .rst      (rst),
        .lanes_in (lanes_lo),
        .write    (write_lo),
        .fill     (fill_lo),
        .lanes    (half_lo)
    );

    half_buffer half_hi_inst (
        .clk      (clk),
        .rst      (rst),
        .lanes_in (lanes_hi),
        .write    (write_hi),
        .fill     (fill_hi),
        .lanes    (half_hi)
    );

    word_emitter word_emitter_inst (
        .clk      (clk),
        .rst      (rst),
        .emit_req (emit_req),
        .half_lo  (half_lo),
        .half_hi  (half_hi),
        .word     (word),
        .wr_en    (wr_en)
    );

endmodule

`default_nettype wire

/* design/ring_pointer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "loader_cfg.svh"

module ring_pointer (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     group_valid,
    input  mk_loader_pkg::group_t    group,
    output mk_loader_pkg::slot_ctl_t slot_ctl,
    output mk_loader_pkg::emit_req_t emit_req,
    output logic                     busy
);

    localparam int N  = `LD_NUM_PES;
    localparam int PW = `LD_LOG2_PES;

    logic [PW:0]              ptr;
    logic [PW:0]              ptr_next;
    logic                     cur_half;
    logic [PW+1:0]            pos_ext;
    logic [PW+1:0]            fill_end;
    logic [PW+1:0]            pad_end;
    logic                     crossing;
    logic                     half_done;
    mk_loader_pkg::emit_req_t req_next;

    assign cur_half  = ptr[PW];
    assign pos_ext   = {2'b00, ptr[PW-1:0]};
    assign fill_end  = pos_ext + {1'b0, group.len};
    assign half_done = fill_end >= (PW + 2)'(N);
    assign crossing  = fill_end > (PW + 2)'(N);
    // pad up to the end of the half holding the last element
    assign pad_end   = crossing ? (PW + 2)'(2 * N) - pos_ext : (PW + 2)'(N) - pos_ext;

    for (genvar s = 0; s < 2 * N; s++) begin : g_slot
        logic [PW:0] offset;

        // distance from the pointer, wraps around the ring
        assign offset = (PW + 1)'(s) - ptr;
        assign slot_ctl[s].write = group_valid && (offset < group.len);
        assign slot_ctl[s].fill  = group_valid && group.last_row &&
                                   (offset >= group.len) && ({1'b0, offset} < pad_end);
        assign slot_ctl[s].src   = offset[PW-1:0];
    end

    always_comb begin
        req_next = '0;
        ptr_next = ptr + group.len;
        req_next.first_half = cur_half;
        if (group.last_row) begin
            req_next.first_valid = 1'b1;
            req_next.block_end   = 1'b1;
            req_next.last_block  = group.last_block;
            if (crossing) begin
                req_next.second_valid = 1'b1;
                ptr_next = {cur_half, {PW{1'b0}}};
            end else begin
                ptr_next = {~cur_half, {PW{1'b0}}};
            end
        end else begin
            req_next.first_valid = half_done;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ptr      <= '0;
            emit_req <= '0;
            busy     <= 1'b0;
        end else begin
            // high while the emitter flushes the second word
            busy <= emit_req.second_valid;
            if (group_valid) begin
                ptr      <= ptr_next;
                emit_req <= req_next;
            end else begin
                emit_req <= '0;
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst) busy |-> !group_valid)
        else $error("group strobe while busy");

    assert property (@(posedge clk) disable iff (rst) group_valid |-> group.len <= N)
        else $error("group length %0d above lane count", group.len);

endmodule

`default_nettype wire

/* design/word_emitter.sv */
`timescale 1ns/1ps
`default_nettype none

module word_emitter (
    input  logic                      clk,
    input  logic                      rst,
    input  mk_loader_pkg::emit_req_t  emit_req,
    input  mk_loader_pkg::half_t      half_lo,
    input  mk_loader_pkg::half_t      half_hi,
    output mk_loader_pkg::fifo_word_t word,
    output logic                      wr_en
);

    mk_loader_pkg::half_t      word_lanes;
    logic                      word_block_end;
    logic                      word_last_block;
    mk_loader_pkg::fifo_word_t pend_word;
    logic                      pend_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_en           <= 1'b0;
            pend_valid      <= 1'b0;
            word_block_end  <= 1'b0;
            word_last_block <= 1'b0;
        end else if (pend_valid) begin
            // second word of a crossing block end
            wr_en           <= 1'b1;
            pend_valid      <= 1'b0;
            word_block_end  <= pend_word.block_end;
            word_last_block <= pend_word.last_block;
        end else begin
            wr_en      <= emit_req.first_valid;
            pend_valid <= emit_req.second_valid;
            // flags only when this is the final word of the request
            word_block_end  <= emit_req.first_valid && !emit_req.second_valid &&
                               emit_req.block_end;
            word_last_block <= emit_req.first_valid && !emit_req.second_valid &&
                               emit_req.last_block;
        end
    end

    always_ff @(posedge clk) begin
        if (pend_valid) begin
            word_lanes <= pend_word.lanes;
        end else if (emit_req.first_valid) begin
            word_lanes <= emit_req.first_half ? half_hi : half_lo;
        end
        if (emit_req.second_valid) begin
            pend_word.lanes      <= emit_req.first_half ? half_lo : half_hi;
            pend_word.block_end  <= emit_req.block_end;
            pend_word.last_block <= emit_req.last_block;
        end
    end

    assign word = '{lanes: word_lanes, block_end: word_block_end, last_block: word_last_block};

    assert property (@(posedge clk) disable iff (rst) pend_valid |-> !emit_req.first_valid)
        else $error("emit request while second word pending");

endmodule

`default_nettype wire
